// File: Makefile
TOP := tb_axi_async_subsys

.PHONY: run lint clean

run:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
    parameter int width      = 8,
    parameter int depth_log2 = 3
) (
    input  wire logic             wr_clk,
    input  wire logic             wr_rstn,
    input  wire logic             wr_en,
    input  wire logic [width-1:0] wr_data,
    output logic                  wr_full,
    input  wire logic             rd_clk,
    input  wire logic             rd_rstn,
    input  wire logic             rd_en,
    output logic [width-1:0]      rd_data,
    output logic                  rd_empty
);

    localparam int ptr_w = depth_log2 + 1;  // Extra wrap bit

    logic [width-1:0] mem [2**depth_log2];
    logic [ptr_w-1:0] wbin;
    logic [ptr_w-1:0] wbin_next;
    logic [ptr_w-1:0] wgray;
    logic [ptr_w-1:0] rbin;
    logic [ptr_w-1:0] rbin_next;
    logic [ptr_w-1:0] rgray;
    logic [ptr_w-1:0] wgray_s1;
    logic [ptr_w-1:0] wgray_s2;
    logic [ptr_w-1:0] rgray_s1;
    logic [ptr_w-1:0] rgray_s2;

    assign wbin_next = wbin + ptr_w'(1);
    assign rbin_next = rbin + ptr_w'(1);

    always_ff @(posedge wr_clk) begin
        if (!wr_rstn) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_s1 <= '0;
            rgray_s2 <= '0;
        end else begin
            if (wr_en) begin
                wbin  <= wbin_next;
                wgray <= wbin_next ^ (wbin_next >> 1);
            end
            rgray_s1 <= rgray;  // Two-flop sync of read pointer
            rgray_s2 <= rgray_s1;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en) mem[wbin[depth_log2-1:0]] <= wr_data;
    end

    // Full when the top two gray bits differ and the rest match
    assign wr_full = (wgray == (rgray_s2 ^ {2'b11, {(ptr_w-2){1'b0}}}));

    always_ff @(posedge rd_clk) begin
        if (!rd_rstn) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_s1 <= '0;
            wgray_s2 <= '0;
        end else begin
            if (rd_en) begin
                rbin  <= rbin_next;
                rgray <= rbin_next ^ (rbin_next >> 1);
            end
            wgray_s1 <= wgray;
            wgray_s2 <= wgray_s1;
        end
    end

    assign rd_empty = (rgray == wgray_s2);
    assign rd_data  = mem[rbin[depth_log2-1:0]];  // Head entry, popped by rd_en

    a_no_overflow: assert property (@(posedge wr_clk) disable iff (!wr_rstn)
        !(wr_en && wr_full));
    a_no_underflow: assert property (@(posedge rd_clk) disable iff (!rd_rstn)
        !(rd_en && rd_empty));

endmodule

`default_nettype wire

// File: axi_async_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module axi_async_subsys #(
    parameter int fifo_depth_log2 = 3,
    parameter int mem_words       = 256
) (
    input  wire logic                      BUS_CLK,
    input  wire logic                      BUS_RSTN,
    input  wire logic                      SLAVE_CLK,
    input  wire logic                      SLAVE_RSTN,
    input  wire axi_bridge_pkg::addr_req_t bus_aw,
    input  wire logic                      bus_aw_valid,
    output logic                           bus_aw_ready,
    input  wire axi_bridge_pkg::wr_beat_t  bus_w,
    input  wire logic                      bus_w_valid,
    output logic                           bus_w_ready,
    output axi_bridge_pkg::wr_resp_t       bus_b,
    output logic                           bus_b_valid,
    input  wire logic                      bus_b_ready,
    input  wire axi_bridge_pkg::addr_req_t bus_ar,
    input  wire logic                      bus_ar_valid,
    output logic                           bus_ar_ready,
    output axi_bridge_pkg::rd_beat_t       bus_r,
    output logic                           bus_r_valid,
    input  wire logic                      bus_r_ready
);

    axi_bridge_pkg::addr_req_t slv_aw;
    logic                      slv_aw_valid;
    logic                      slv_aw_ready;
    axi_bridge_pkg::wr_beat_t  slv_w;
    logic                      slv_w_valid;
    logic                      slv_w_ready;
    axi_bridge_pkg::wr_resp_t  slv_b;
    logic                      slv_b_valid;
    logic                      slv_b_ready;
    axi_bridge_pkg::addr_req_t slv_ar;
    logic                      slv_ar_valid;
    logic                      slv_ar_ready;
    axi_bridge_pkg::rd_beat_t  slv_r;
    logic                      slv_r_valid;
    logic                      slv_r_ready;

    // Port names line up one to one with the bridge
    slave_axi_async #(
        .fifo_depth_log2 (fifo_depth_log2)
    ) i_bridge (.*);

    axi_mem_slave #(
        .mem_words (mem_words)
    ) i_mem_slave (
        .SLAVE_CLK (SLAVE_CLK), .SLAVE_RSTN (SLAVE_RSTN),
        .aw (slv_aw), .aw_valid (slv_aw_valid), .aw_ready (slv_aw_ready),
        .w  (slv_w),  .w_valid  (slv_w_valid),  .w_ready  (slv_w_ready),
        .b  (slv_b),  .b_valid  (slv_b_valid),  .b_ready  (slv_b_ready),
        .ar (slv_ar), .ar_valid (slv_ar_valid), .ar_ready (slv_ar_ready),
        .r  (slv_r),  .r_valid  (slv_r_valid),  .r_ready  (slv_r_ready)
    );

endmodule

`default_nettype wire

// File: axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

    localparam logic [1:0] burst_fixed = 2'd0;
    localparam logic [1:0] burst_incr  = 2'd1;  // WRAP falls through to INCR

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
    } addr_req_t;  // AW and AR

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } wr_beat_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } wr_resp_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } rd_beat_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_t;

    typedef enum logic {
        rd_idle,
        rd_data
    } rd_state_t;

endpackage

`default_nettype wire

// File: axi_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave #(
    parameter int mem_words = 256
) (
    input  wire logic                      SLAVE_CLK,
    input  wire logic                      SLAVE_RSTN,
    input  wire axi_bridge_pkg::addr_req_t aw,
    input  wire logic                      aw_valid,
    output logic                           aw_ready,
    input  wire axi_bridge_pkg::wr_beat_t  w,
    input  wire logic                      w_valid,
    output logic                           w_ready,
    output axi_bridge_pkg::wr_resp_t       b,
    output logic                           b_valid,
    input  wire logic                      b_ready,
    input  wire axi_bridge_pkg::addr_req_t ar,
    input  wire logic                      ar_valid,
    output logic                           ar_ready,
    output axi_bridge_pkg::rd_beat_t       r,
    output logic                           r_valid,
    input  wire logic                      r_ready
);

    localparam int idx_w = $clog2(mem_words);

    logic [31:0] mem [mem_words];

    axi_bridge_pkg::wr_state_t wr_st;
    logic [3:0]                wr_id;
    logic [29:0]               wr_addr;  // Word address
    logic [1:0]                wr_burst;
    logic [7:0]                wr_cnt;   // Beats left after this one
    logic                      wr_err;
    logic                      wr_hit;

    axi_bridge_pkg::rd_state_t rd_st;
    logic [29:0]               rd_addr;
    logic [1:0]                rd_burst;
    logic [7:0]                rd_cnt;
    logic [29:0]               rd_src;   // Word address of the beat being loaded
    logic                      rd_hit;
    logic                      rd_load;

    assign aw_ready = (wr_st == axi_bridge_pkg::wr_idle);
    assign w_ready  = (wr_st == axi_bridge_pkg::wr_data);
    assign b_valid  = (wr_st == axi_bridge_pkg::wr_resp);
    assign b        = '{id: wr_id,
                        resp: wr_err ? axi_bridge_pkg::resp_slverr : axi_bridge_pkg::resp_okay};
    assign wr_hit   = (wr_addr < 30'(mem_words));

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            wr_st <= axi_bridge_pkg::wr_idle;
        end else begin
            case (wr_st)
                axi_bridge_pkg::wr_idle: if (aw_valid) begin
                    wr_id    <= aw.id;
                    wr_addr  <= aw.addr[31:2];
                    wr_burst <= aw.burst;
                    wr_cnt   <= aw.len;
                    wr_err   <= 1'b0;
                    wr_st    <= axi_bridge_pkg::wr_data;
                end
                axi_bridge_pkg::wr_data: if (w_valid) begin
                    wr_err  <= wr_err || !wr_hit;
                    wr_addr <= wr_addr + 30'(wr_burst != axi_bridge_pkg::burst_fixed);
                    wr_cnt  <= wr_cnt - 8'd1;
                    if (wr_cnt == 8'd0) wr_st <= axi_bridge_pkg::wr_resp;
                end
                default: if (b_ready) wr_st <= axi_bridge_pkg::wr_idle;
            endcase
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (w_valid && w_ready && wr_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) mem[wr_addr[idx_w-1:0]][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

    // W last has to line up with the AW length
    a_wlast: assert property (@(posedge SLAVE_CLK) disable iff (!SLAVE_RSTN)
        w_valid && w_ready |-> (w.last == (wr_cnt == 8'd0)));

    assign ar_ready = (rd_st == axi_bridge_pkg::rd_idle);
    assign r_valid  = (rd_st == axi_bridge_pkg::rd_data);
    assign rd_src   = ar_ready ? ar.addr[31:2]
                               : rd_addr + 30'(rd_burst != axi_bridge_pkg::burst_fixed);
    assign rd_hit   = (rd_src < 30'(mem_words));
    assign rd_load  = ar_ready ? ar_valid : (r_ready && !r.last);

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN)
            rd_st <= axi_bridge_pkg::rd_idle;
        else if (ar_valid && ar_ready)
            rd_st <= axi_bridge_pkg::rd_data;
        else if (r_valid && r_ready && r.last)
            rd_st <= axi_bridge_pkg::rd_idle;
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (rd_load) begin
            rd_addr <= rd_src;
            r.data  <= rd_hit ? mem[rd_src[idx_w-1:0]] : 32'd0;
            r.resp  <= rd_hit ? axi_bridge_pkg::resp_okay : axi_bridge_pkg::resp_slverr;
            if (ar_ready) begin  // First beat
                r.id     <= ar.id;
                rd_burst <= ar.burst;
                rd_cnt   <= ar.len;
                r.last   <= (ar.len == 8'd0);
            end else begin
                rd_cnt <= rd_cnt - 8'd1;
                r.last <= (rd_cnt == 8'd1);
            end
        end
    end

endmodule

`default_nettype wire

// File: cdc_channel.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_channel #(
    parameter int width      = 8,
    parameter int depth_log2 = 3
) (
    input  wire logic             in_clk,
    input  wire logic             in_rstn,
    input  wire logic             in_valid,
    input  wire logic [width-1:0] in_data,
    output logic                  in_ready,
    input  wire logic             out_clk,
    input  wire logic             out_rstn,
    output logic                  out_valid,
    output logic [width-1:0]      out_data,
    input  wire logic             out_ready
);

    logic             wr_full;
    logic             rd_empty;
    logic             pop;
    logic             prefetch;  // Output register holds nothing useful
    logic [width-1:0] fifo_q;

    assign in_ready  = in_rstn && !wr_full;
    assign out_valid = !prefetch;
    assign pop       = !rd_empty && (prefetch || (out_valid && out_ready));

    always_ff @(posedge out_clk) begin
        if (!out_rstn)
            prefetch <= 1'b1;
        else if (rd_empty && out_valid && out_ready)
            prefetch <= 1'b1;  // Drained
        else if (pop)
            prefetch <= 1'b0;
    end

    always_ff @(posedge out_clk) begin
        if (pop) out_data <= fifo_q;
    end

    async_fifo #(
        .width      (width),
        .depth_log2 (depth_log2)
    ) i_fifo (
        .wr_clk   (in_clk),
        .wr_rstn  (in_rstn),
        .wr_en    (in_valid && in_ready),
        .wr_data  (in_data),
        .wr_full  (wr_full),
        .rd_clk   (out_clk),
        .rd_rstn  (out_rstn),
        .rd_en    (pop),
        .rd_data  (fifo_q),
        .rd_empty (rd_empty)
    );

    a_out_hold: assert property (@(posedge out_clk) disable iff (!out_rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: sim.f
axi_bridge_pkg.sv
async_fifo.sv
cdc_channel.sv
slave_axi_async.sv
axi_mem_slave.sv
axi_async_subsys.sv
tb_clock_gen.sv
tb_axi_async_subsys.sv

// File: slave_axi_async.sv
`timescale 1ns/1ps
`default_nettype none

module slave_axi_async #(
    parameter int fifo_depth_log2 = 3
) (
    input  wire logic                      BUS_CLK,
    input  wire logic                      BUS_RSTN,
    input  wire logic                      SLAVE_CLK,
    input  wire logic                      SLAVE_RSTN,
    input  wire axi_bridge_pkg::addr_req_t bus_aw,
    input  wire logic                      bus_aw_valid,
    output logic                           bus_aw_ready,
    input  wire axi_bridge_pkg::wr_beat_t  bus_w,
    input  wire logic                      bus_w_valid,
    output logic                           bus_w_ready,
    output axi_bridge_pkg::wr_resp_t       bus_b,
    output logic                           bus_b_valid,
    input  wire logic                      bus_b_ready,
    input  wire axi_bridge_pkg::addr_req_t bus_ar,
    input  wire logic                      bus_ar_valid,
    output logic                           bus_ar_ready,
    output axi_bridge_pkg::rd_beat_t       bus_r,
    output logic                           bus_r_valid,
    input  wire logic                      bus_r_ready,
    output axi_bridge_pkg::addr_req_t      slv_aw,
    output logic                           slv_aw_valid,
    input  wire logic                      slv_aw_ready,
    output axi_bridge_pkg::wr_beat_t       slv_w,
    output logic                           slv_w_valid,
    input  wire logic                      slv_w_ready,
    input  wire axi_bridge_pkg::wr_resp_t  slv_b,
    input  wire logic                      slv_b_valid,
    output logic                           slv_b_ready,
    output axi_bridge_pkg::addr_req_t      slv_ar,
    output logic                           slv_ar_valid,
    input  wire logic                      slv_ar_ready,
    input  wire axi_bridge_pkg::rd_beat_t  slv_r,
    input  wire logic                      slv_r_valid,
    output logic                           slv_r_ready
);

    logic [1:0] slv_rstn_bus;  // SLAVE_RSTN seen from BUS_CLK
    logic [1:0] bus_rstn_slv;  // BUS_RSTN seen from SLAVE_CLK
    logic       bus_rstn_all;
    logic       slv_rstn_all;

    always_ff @(posedge BUS_CLK) begin
        if (!BUS_RSTN)
            slv_rstn_bus <= 2'b00;
        else
            slv_rstn_bus <= {slv_rstn_bus[0], SLAVE_RSTN};
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN)
            bus_rstn_slv <= 2'b00;
        else
            bus_rstn_slv <= {bus_rstn_slv[0], BUS_RSTN};
    end

    // Either side in reset holds both ends of every crossing
    assign bus_rstn_all = BUS_RSTN && slv_rstn_bus[1];
    assign slv_rstn_all = SLAVE_RSTN && bus_rstn_slv[1];

    cdc_channel #(
        .width ($bits(axi_bridge_pkg::addr_req_t)), .depth_log2 (fifo_depth_log2)
    ) i_aw_cdc (
        .in_clk (BUS_CLK), .in_rstn (bus_rstn_all), .in_valid (bus_aw_valid),
        .in_data (bus_aw), .in_ready (bus_aw_ready),
        .out_clk (SLAVE_CLK), .out_rstn (slv_rstn_all), .out_valid (slv_aw_valid),
        .out_data (slv_aw), .out_ready (slv_aw_ready)
    );

    cdc_channel #(
        .width ($bits(axi_bridge_pkg::wr_beat_t)), .depth_log2 (fifo_depth_log2)
    ) i_w_cdc (
        .in_clk (BUS_CLK), .in_rstn (bus_rstn_all), .in_valid (bus_w_valid),
        .in_data (bus_w), .in_ready (bus_w_ready),
        .out_clk (SLAVE_CLK), .out_rstn (slv_rstn_all), .out_valid (slv_w_valid),
        .out_data (slv_w), .out_ready (slv_w_ready)
    );

    cdc_channel #(
        .width ($bits(axi_bridge_pkg::wr_resp_t)), .depth_log2 (fifo_depth_log2)
    ) i_b_cdc (  // Slave to bus
        .in_clk (SLAVE_CLK), .in_rstn (slv_rstn_all), .in_valid (slv_b_valid),
        .in_data (slv_b), .in_ready (slv_b_ready),
        .out_clk (BUS_CLK), .out_rstn (bus_rstn_all), .out_valid (bus_b_valid),
        .out_data (bus_b), .out_ready (bus_b_ready)
    );

    cdc_channel #(
        .width ($bits(axi_bridge_pkg::addr_req_t)), .depth_log2 (fifo_depth_log2)
    ) i_ar_cdc (
        .in_clk (BUS_CLK), .in_rstn (bus_rstn_all), .in_valid (bus_ar_valid),
        .in_data (bus_ar), .in_ready (bus_ar_ready),
        .out_clk (SLAVE_CLK), .out_rstn (slv_rstn_all), .out_valid (slv_ar_valid),
        .out_data (slv_ar), .out_ready (slv_ar_ready)
    );

    cdc_channel #(
        .width ($bits(axi_bridge_pkg::rd_beat_t)), .depth_log2 (fifo_depth_log2)
    ) i_r_cdc (  // Slave to bus
        .in_clk (SLAVE_CLK), .in_rstn (slv_rstn_all), .in_valid (slv_r_valid),
        .in_data (slv_r), .in_ready (slv_r_ready),
        .out_clk (BUS_CLK), .out_rstn (bus_rstn_all), .out_valid (bus_r_valid),
        .out_data (bus_r), .out_ready (bus_r_ready)
    );

endmodule

`default_nettype wire

// File: tb_axi_async_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_async_subsys;

    localparam int mem_words = 256;
    localparam int idx_w     = $clog2(mem_words);

    typedef struct packed {
        logic [3:0]  op;        // 1 write, 0 read
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  burst;
        logic [3:0]  strb;
        logic [31:0] base;
        logic [1:0]  exp_resp;
        logic        throttle;  // Random bready/rready
    } tx_t;

    logic                      SLAVE_CLK;
    logic                      SLAVE_RSTN;
    logic                      BUS_CLK;
    logic                      BUS_RSTN;
    axi_bridge_pkg::addr_req_t bus_aw;
    logic                      bus_aw_valid;
    logic                      bus_aw_ready;
    axi_bridge_pkg::wr_beat_t  bus_w;
    logic                      bus_w_valid;
    logic                      bus_w_ready;
    axi_bridge_pkg::wr_resp_t  bus_b;
    logic                      bus_b_valid;
    logic                      bus_b_ready;
    axi_bridge_pkg::addr_req_t bus_ar;
    logic                      bus_ar_valid;
    logic                      bus_ar_ready;
    axi_bridge_pkg::rd_beat_t  bus_r;
    logic                      bus_r_valid;
    logic                      bus_r_ready;

    tx_t         txq [$];
    logic [31:0] ref_mem [mem_words];
    int          total_beats;
    logic        loaded;
    integer      seed = 60;

    tb_clock_gen #(.period_ns (40), .reset_cycles (5)) i_slave_clk_gen (
        .clk  (SLAVE_CLK),
        .rstn (SLAVE_RSTN)
    );

    tb_clock_gen #(.period_ns (28), .reset_cycles (5)) i_bus_clk_gen (
        .clk  (BUS_CLK),
        .rstn (BUS_RSTN)
    );

    axi_async_subsys #(
        .fifo_depth_log2 (3),
        .mem_words       (mem_words)
    ) i_axi_async_subsys (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0t ns: %s, got %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic to_drive_point();
        @(posedge BUS_CLK);
        #2;
    endtask

    task automatic expect_no_response(input string when);
        check_value(32'(bus_b_valid), 32'd0, {"unrequested bvalid ", when});
        check_value(32'(bus_r_valid), 32'd0, {"unrequested rvalid ", when});
    endtask

    function automatic logic [31:0] beat_word(input tx_t tx, input int k);
        return (tx.addr >> 2) + ((tx.burst == axi_bridge_pkg::burst_incr) ? 32'(k) : 32'd0);
    endfunction

    task automatic load_transactions();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f [9];
        tx_t         tx;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tb_input.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin  // Skip comments
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (fields != 9)
                        abort_run({"malformed line in tb_input.txt: ", line});
                    tx = '{op: f[0][3:0], id: f[1][3:0], addr: f[2], len: f[3][7:0],
                           burst: f[4][1:0], strb: f[5][3:0], base: f[6],
                           exp_resp: f[7][1:0], throttle: f[8][0]};
                    txq.push_back(tx);
                    total_beats += int'(tx.len) + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_write(input tx_t tx);
        logic [31:0] data;
        logic [31:0] word;
        logic [31:0] coin;
        logic [1:0]  model_resp;
        logic        got;
        model_resp   = axi_bridge_pkg::resp_okay;
        bus_aw       = '{id: tx.id, addr: tx.addr, len: tx.len, burst: tx.burst};
        bus_aw_valid = 1'b1;
        while (!bus_aw_ready) to_drive_point();
        to_drive_point();
        bus_aw_valid = 1'b0;
        for (int k = 0; k <= int'(tx.len); k++) begin
            data        = tx.base + 32'(k);
            bus_w       = '{data: data, strb: tx.strb, last: (k == int'(tx.len))};
            bus_w_valid = 1'b1;
            while (!bus_w_ready) to_drive_point();
            to_drive_point();
            word = beat_word(tx, k);
            if (word < 32'(mem_words)) begin
                for (int i = 0; i < 4; i++) begin
                    if (tx.strb[i])
                        ref_mem[word[idx_w-1:0]][8*i +: 8] = data[8*i +: 8];
                end
            end else begin
                model_resp = axi_bridge_pkg::resp_slverr;  // Beat dropped
            end
        end
        bus_w_valid = 1'b0;
        check_value(32'(model_resp), 32'(tx.exp_resp), "B resp in tb_input.txt vs range rule");
        got = 1'b0;
        while (!got) begin
            coin        = $random(seed);
            bus_b_ready = tx.throttle ? coin[0] : 1'b1;
            if (bus_b_valid && bus_b_ready) begin
                check_value(32'(bus_b.id), 32'(tx.id), "B id");
                check_value(32'(bus_b.resp), 32'(tx.exp_resp), "B resp");
                got = 1'b1;
            end
            to_drive_point();
        end
        bus_b_ready = 1'b0;
    endtask

    task automatic run_read(input tx_t tx);
        logic [31:0] word;
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        logic [1:0]  worst;
        logic [31:0] coin;
        int          k;
        bus_ar       = '{id: tx.id, addr: tx.addr, len: tx.len, burst: tx.burst};
        bus_ar_valid = 1'b1;
        while (!bus_ar_ready) to_drive_point();
        to_drive_point();
        bus_ar_valid = 1'b0;
        worst = axi_bridge_pkg::resp_okay;
        k     = 0;
        while (k <= int'(tx.len)) begin
            coin        = $random(seed);
            bus_r_ready = tx.throttle ? coin[0] : 1'b1;
            if (bus_r_valid && bus_r_ready) begin
                word = beat_word(tx, k);
                if (word < 32'(mem_words)) begin
                    exp_data = ref_mem[word[idx_w-1:0]];
                    exp_resp = axi_bridge_pkg::resp_okay;
                end else begin
                    exp_data = 32'd0;  // Outside memory reads as zero
                    exp_resp = axi_bridge_pkg::resp_slverr;
                end
                check_value(32'(bus_r.id), 32'(tx.id), $sformatf("R id, beat %0d", k));
                check_value(bus_r.data, exp_data, $sformatf("R data, beat %0d", k));
                check_value(32'(bus_r.resp), 32'(exp_resp), $sformatf("R resp, beat %0d", k));
                check_value(32'(bus_r.last), 32'(k == int'(tx.len)),
                            $sformatf("R last, beat %0d", k));
                if (exp_resp == axi_bridge_pkg::resp_slverr) worst = exp_resp;
                k++;
            end
            to_drive_point();
        end
        bus_r_ready = 1'b0;
        check_value(32'(worst), 32'(tx.exp_resp), "worst R resp vs tb_input.txt");
    endtask

    initial begin
        longint limit_ns;
        wait (loaded === 1'b1);
        limit_ns = longint'(total_beats) * 40 * 40 + 20000;  // 40 slave periods per beat
        #(limit_ns);
        abort_run("timeout: the transactions did not finish in time");
    end

    initial begin
        int wait_cycles;
        loaded       = 1'b0;
        total_beats  = 0;
        bus_aw       = '0;
        bus_aw_valid = 1'b0;
        bus_w        = '0;
        bus_w_valid  = 1'b0;
        bus_b_ready  = 1'b0;
        bus_ar       = '0;
        bus_ar_valid = 1'b0;
        bus_r_ready  = 1'b0;
        load_transactions();
        loaded = 1'b1;
        wait (BUS_RSTN && SLAVE_RSTN);
        to_drive_point();
        wait_cycles = 0;
        while (!(bus_aw_ready && bus_w_ready && bus_ar_ready) && wait_cycles < 40) begin
            expect_no_response("after reset");
            to_drive_point();
            wait_cycles++;
        end
        check_value(32'(bus_aw_ready && bus_w_ready && bus_ar_ready), 32'd1,
                    "AW, W and AR ready after reset");
        foreach (txq[i]) begin
            expect_no_response("before a transaction");
            if (txq[i].op == 4'd1)
                run_write(txq[i]);
            else
                run_read(txq[i]);
        end
        repeat (50) begin
            expect_no_response("after the last transaction");
            to_drive_point();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rstn = 1'b1;  // Released just after an edge
    end

endmodule

`default_nettype wire

// File: tb_input.txt
# op id addr len burst strb base exp_resp throttle (hex; op 1 write 0 read; burst 0 fixed 1 incr)
# write beat k carries base+k; exp_resp is the B response or the worst R response of the burst
1 1 00000010 03 1 f 11110000 0 0
0 2 00000010 03 1 0 00000000 0 0
1 3 00000014 01 1 3 0000aabb 0 0
0 4 00000010 03 1 0 00000000 0 0
1 5 00000040 03 0 f 55550000 0 0
1 6 00000040 02 0 6 66660000 0 0
0 7 00000040 00 1 0 00000000 0 0
1 8 000003f8 03 1 f 77770000 2 0
0 9 000003f8 03 1 0 00000000 2 0
0 a 00001000 01 1 0 00000000 2 0
1 b 00000000 00 1 f c0c0c0c0 0 0
1 c 00000400 00 1 f 88888888 2 0
0 d 00000000 00 1 0 00000000 0 0
1 e 00000100 0f 1 f 99990000 0 1
0 f 00000100 0f 1 0 00000000 0 1
1 0 00000200 07 1 f 12340000 0 1
0 1 00000200 07 1 0 00000000 0 1
0 2 00000010 03 1 0 00000000 0 1
